// File: src/axil_mon_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types and fixed limits for the AXI-lite bus monitor
// Only valid, ready and response codes are observed, no address or data
// Outstanding counters are CNT_W bits wide and wrap past all ones
// Stall limits are fixed here and apply to every channel of a group
//////////////////////////////////////////////////////////////////////
package axil_mon_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths and limits

	localparam int CNT_W = 4;
	localparam int STALL_W = 4;
	localparam int REQ_STALL_LIMIT = 12;
	localparam int RSP_STALL_LIMIT = 12;

	typedef logic [CNT_W-1:0] count_t;
	typedef logic [STALL_W-1:0] stall_t;
	typedef logic [1:0] resp_t;

	// Exclusive access code, never legal on AXI-lite
	localparam resp_t RESP_EXOKAY = 2'b01;

	// One below all ones, the last safe count before a request
	localparam count_t CNT_NEAR_FULL = {{(CNT_W-1){1'b1}}, 1'b0};

	// Stall count seen on the cycle that completes the limit
	localparam stall_t REQ_STALL_LAST = stall_t'(REQ_STALL_LIMIT - 1);
	localparam stall_t RSP_STALL_LAST = stall_t'(RSP_STALL_LIMIT - 1);

	//////////////////////////////////////////////////////////////////////
	// Bus and result structs

	typedef struct packed {
		logic awvalid;
		logic awready;
		logic wvalid;
		logic wready;
		logic bvalid;
		logic bready;
		resp_t bresp;
	} wr_bus_t;

	typedef struct packed {
		logic arvalid;
		logic arready;
		logic rvalid;
		logic rready;
		resp_t rresp;
	} rd_bus_t;

	// Single-cycle fault strobes, first field is the lowest code
	typedef struct packed {
		logic aw_stall;
		logic w_stall;
		logic b_stall;
		logic b_orphan;
		logic b_exokay;
		logic wr_overflow;
	} wr_fault_t;

	typedef struct packed {
		logic ar_stall;
		logic r_stall;
		logic r_orphan;
		logic r_exokay;
		logic rd_overflow;
	} rd_fault_t;

	// Write part sits in the upper bits
	typedef struct packed {
		wr_fault_t wr;
		rd_fault_t rd;
	} fault_vec_t;

	localparam int FAULT_N = $bits(fault_vec_t);

	typedef struct packed {
		count_t awr;
		count_t wr;
		count_t rd;
	} counts_t;

	// Codes follow the field order of fault_vec_t
	typedef enum logic [3:0] {
		FC_NONE = 4'd0,
		FC_AW_STALL = 4'd1,
		FC_W_STALL = 4'd2,
		FC_B_STALL = 4'd3,
		FC_B_ORPHAN = 4'd4,
		FC_B_EXOKAY = 4'd5,
		FC_WR_OVERFLOW = 4'd6,
		FC_AR_STALL = 4'd7,
		FC_R_STALL = 4'd8,
		FC_R_ORPHAN = 4'd9,
		FC_R_EXOKAY = 4'd10,
		FC_RD_OVERFLOW = 4'd11
	} fault_code_t;

	typedef enum logic {
		LOG_CLEAR = 1'b0,
		LOG_HELD = 1'b1
	} log_state_t;

	//////////////////////////////////////////////////////////////////////
	// Shared next-value helpers

	// Up on request, down on acknowledge, both leaves it alone
	function automatic count_t count_next(input count_t cnt, input logic inc,
		input logic dec);
		count_t nxt;
		nxt = cnt;
		if (inc && !dec)
			nxt = cnt + 1'b1;
		else if (dec && !inc)
			nxt = cnt - 1'b1;
		return nxt;
	endfunction

	// Counts stalled cycles and parks on the last value
	function automatic stall_t stall_next(input stall_t cnt, input logic stalled,
		input stall_t last);
		stall_t nxt;
		if (!stalled)
			nxt = '0;
		else if (cnt == last)
			nxt = cnt;
		else
			nxt = cnt + 1'b1;
		return nxt;
	endfunction

endpackage

// File: src/axil_wr_monitor.sv
//////////////////////////////////////////////////////////////////////
// Write side of the AXI-lite monitor, purely passive
// A B handshake retires one address and one data beat together
// AW and W stalls are not counted while bvalid is high
// Fault strobes are combinational and last only for the fault cycle
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module axil_wr_monitor
(
	input  logic                    i_clk,
	input  logic                    i_axi_reset_n,
	input  axil_mon_pkg::wr_bus_t   i_wr_bus,
	output axil_mon_pkg::count_t    o_awr_count,
	output axil_mon_pkg::count_t    o_wr_count,
	output axil_mon_pkg::wr_fault_t o_wr_fault
);

	import axil_mon_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Handshake detection

	logic aw_req;
	logic w_req;
	logic b_ack;

	// Handshakes only count once reset is released
	assign aw_req = i_wr_bus.awvalid && i_wr_bus.awready && i_axi_reset_n;
	assign w_req = i_wr_bus.wvalid && i_wr_bus.wready && i_axi_reset_n;
	assign b_ack = i_wr_bus.bvalid && i_wr_bus.bready && i_axi_reset_n;

	//////////////////////////////////////////////////////////////////////
	// Stall conditions

	logic aw_stalled;
	logic w_stalled;
	logic b_stalled;

	// A pending response may hold off new requests
	assign aw_stalled = i_wr_bus.awvalid && !i_wr_bus.awready && !i_wr_bus.bvalid;
	assign w_stalled = i_wr_bus.wvalid && !i_wr_bus.wready && !i_wr_bus.bvalid;

	// Response side has no exception
	assign b_stalled = i_wr_bus.bvalid && !i_wr_bus.bready;

	stall_t aw_stall_cnt;
	stall_t w_stall_cnt;
	stall_t b_stall_cnt;

	//////////////////////////////////////////////////////////////////////
	// Outstanding and stall counters

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			o_awr_count <= '0;
			o_wr_count <= '0;
			aw_stall_cnt <= '0;
			w_stall_cnt <= '0;
			b_stall_cnt <= '0;
		end
		else
		begin
			// Write acknowledge retires both counts
			o_awr_count <= count_next(o_awr_count, aw_req, b_ack);
			o_wr_count <= count_next(o_wr_count, w_req, b_ack);

			aw_stall_cnt <= stall_next(aw_stall_cnt, aw_stalled, REQ_STALL_LAST);
			w_stall_cnt <= stall_next(w_stall_cnt, w_stalled, REQ_STALL_LAST);
			b_stall_cnt <= stall_next(b_stall_cnt, b_stalled, RSP_STALL_LAST);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Fault strobes

	logic awr_empty;
	logic wr_empty;
	logic awr_near_full;
	logic wr_near_full;

	assign awr_empty = (o_awr_count == '0);
	assign wr_empty = (o_wr_count == '0);
	assign awr_near_full = (o_awr_count == CNT_NEAR_FULL);
	assign wr_near_full = (o_wr_count == CNT_NEAR_FULL);

	always_comb
	begin
		// Limit reached on the 12th stalled cycle in a row
		o_wr_fault.aw_stall = aw_stalled && (aw_stall_cnt == REQ_STALL_LAST);
		o_wr_fault.w_stall = w_stalled && (w_stall_cnt == REQ_STALL_LAST);
		o_wr_fault.b_stall = b_stalled && (b_stall_cnt == RSP_STALL_LAST);

		// A response needs both an address and a data beat pending
		o_wr_fault.b_orphan = i_wr_bus.bvalid && (awr_empty || wr_empty);

		// Exclusive response on a bus without exclusive access
		o_wr_fault.b_exokay = i_wr_bus.bvalid && (i_wr_bus.bresp == RESP_EXOKAY);

		// Next request would push a count to all ones
		o_wr_fault.wr_overflow = (aw_req && awr_near_full) || (w_req && wr_near_full);
	end

endmodule

// File: src/axil_rd_monitor.sv
//////////////////////////////////////////////////////////////////////
// Read side of the AXI-lite monitor, purely passive
// AR stalls are not counted while rvalid is high
// An AR and an R handshake in one cycle leave the count unchanged
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module axil_rd_monitor
(
	input  logic                    i_clk,
	input  logic                    i_axi_reset_n,
	input  axil_mon_pkg::rd_bus_t   i_rd_bus,
	output axil_mon_pkg::count_t    o_rd_count,
	output axil_mon_pkg::rd_fault_t o_rd_fault
);

	import axil_mon_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Handshakes and stall conditions

	logic ar_req;
	logic r_ack;

	assign ar_req = i_rd_bus.arvalid && i_rd_bus.arready && i_axi_reset_n;
	assign r_ack = i_rd_bus.rvalid && i_rd_bus.rready && i_axi_reset_n;

	logic ar_stalled;
	logic r_stalled;

	// Returning data can back up the address channel
	assign ar_stalled = i_rd_bus.arvalid && !i_rd_bus.arready && !i_rd_bus.rvalid;
	assign r_stalled = i_rd_bus.rvalid && !i_rd_bus.rready;

	stall_t ar_stall_cnt;
	stall_t r_stall_cnt;

	//////////////////////////////////////////////////////////////////////
	// Counters

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			o_rd_count <= '0;
			ar_stall_cnt <= '0;
			r_stall_cnt <= '0;
		end
		else
		begin
			o_rd_count <= count_next(o_rd_count, ar_req, r_ack);
			ar_stall_cnt <= stall_next(ar_stall_cnt, ar_stalled, REQ_STALL_LAST);
			r_stall_cnt <= stall_next(r_stall_cnt, r_stalled, RSP_STALL_LAST);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Fault strobes

	logic rd_empty;
	logic rd_near_full;

	assign rd_empty = (o_rd_count == '0);
	assign rd_near_full = (o_rd_count == CNT_NEAR_FULL);

	always_comb
	begin
		// Stall limits on request and response
		o_rd_fault.ar_stall = ar_stalled && (ar_stall_cnt == REQ_STALL_LAST);
		o_rd_fault.r_stall = r_stalled && (r_stall_cnt == RSP_STALL_LAST);

		// Read data with nothing requested
		o_rd_fault.r_orphan = i_rd_bus.rvalid && rd_empty;

		// Exclusive response is never legal here
		o_rd_fault.r_exokay = i_rd_bus.rvalid && (i_rd_bus.rresp == RESP_EXOKAY);

		// Request that would reach all ones
		o_rd_fault.rd_overflow = ar_req && rd_near_full;
	end

endmodule

// File: src/axil_fault_log.sv
//////////////////////////////////////////////////////////////////////
// Sticky fault flags and first-fault code for the bus monitor
// Flags and code clear only on reset
// Same-cycle faults resolve to the lowest code
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module axil_fault_log
(
	input  logic                      i_clk,
	input  logic                      i_axi_reset_n,
	input  axil_mon_pkg::wr_fault_t   i_wr_fault,
	input  axil_mon_pkg::rd_fault_t   i_rd_fault,
	output axil_mon_pkg::fault_vec_t  o_fault_flags,
	output logic                      o_fault,
	output axil_mon_pkg::fault_code_t o_first_fault
);

	import axil_mon_pkg::*;

	// Highest set bit is the lowest code
	function automatic fault_code_t first_code(input fault_vec_t vec);
		fault_code_t code;
		code = FC_NONE;
		for (int i = 0; i < FAULT_N; i++)
			if (vec[i])
				code = fault_code_t'(FAULT_N - i);
		return code;
	endfunction

	fault_vec_t strobes;
	logic any_strobe;
	log_state_t state;

	assign strobes = '{wr: i_wr_fault, rd: i_rd_fault};
	assign any_strobe = |strobes;

	// Raised together with the first flag
	assign o_fault = |o_fault_flags;

	//////////////////////////////////////////////////////////////////////
	// Flags and first-fault FSM

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			o_fault_flags <= '0;
			o_first_fault <= FC_NONE;
			state <= LOG_CLEAR;
		end
		else
		begin
			o_fault_flags <= o_fault_flags | strobes;
			case (state)
				LOG_CLEAR:
				begin
					// Code is captured once, on leaving the clear state
					if (any_strobe)
					begin
						o_first_fault <= first_code(strobes);
						state <= LOG_HELD;
					end
				end
				default:
					state <= LOG_HELD;
			endcase
		end
	end

endmodule

// File: src/axil_bus_monitor.sv
//////////////////////////////////////////////////////////////////////
// Passive AXI-lite bus monitor, top level
// Observes handshake and response signals of all five channels
// Never drives the bus and adds no back-pressure
// Reset is synchronous and active low
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module axil_bus_monitor
(
	input  logic                      i_clk,
	input  logic                      i_axi_reset_n,
	input  logic                      i_axi_awvalid,
	input  logic                      i_axi_awready,
	input  logic                      i_axi_wvalid,
	input  logic                      i_axi_wready,
	input  logic                      i_axi_bvalid,
	input  logic                      i_axi_bready,
	input  axil_mon_pkg::resp_t       i_axi_bresp,
	input  logic                      i_axi_arvalid,
	input  logic                      i_axi_arready,
	input  logic                      i_axi_rvalid,
	input  logic                      i_axi_rready,
	input  axil_mon_pkg::resp_t       i_axi_rresp,
	output axil_mon_pkg::counts_t     o_counts,
	output axil_mon_pkg::fault_vec_t  o_fault_flags,
	output logic                      o_fault,
	output axil_mon_pkg::fault_code_t o_first_fault
);

	import axil_mon_pkg::*;

	wr_bus_t wr_bus;
	rd_bus_t rd_bus;
	count_t awr_count;
	count_t wr_count;
	count_t rd_count;
	wr_fault_t wr_fault;
	rd_fault_t rd_fault;

	// Group raw bus inputs per direction
	assign wr_bus = '{awvalid: i_axi_awvalid, awready: i_axi_awready,
		wvalid: i_axi_wvalid, wready: i_axi_wready,
		bvalid: i_axi_bvalid, bready: i_axi_bready, bresp: i_axi_bresp};
	assign rd_bus = '{arvalid: i_axi_arvalid, arready: i_axi_arready,
		rvalid: i_axi_rvalid, rready: i_axi_rready, rresp: i_axi_rresp};

	axil_wr_monitor u_wr_monitor
	(
		.i_clk         (i_clk),
		.i_axi_reset_n (i_axi_reset_n),
		.i_wr_bus      (wr_bus),
		.o_awr_count   (awr_count),
		.o_wr_count    (wr_count),
		.o_wr_fault    (wr_fault)
	);

	axil_rd_monitor u_rd_monitor
	(
		.i_clk         (i_clk),
		.i_axi_reset_n (i_axi_reset_n),
		.i_rd_bus      (rd_bus),
		.o_rd_count    (rd_count),
		.o_rd_fault    (rd_fault)
	);

	axil_fault_log u_fault_log
	(
		.i_clk         (i_clk),
		.i_axi_reset_n (i_axi_reset_n),
		.i_wr_fault    (wr_fault),
		.i_rd_fault    (rd_fault),
		.o_fault_flags (o_fault_flags),
		.o_fault       (o_fault),
		.o_first_fault (o_first_fault)
	);

	// Outstanding counts from both monitors
	assign o_counts = '{awr: awr_count, wr: wr_count, rd: rd_count};

endmodule

// File: verification/axil_monitor_checker.sv
//////////////////////////////////////////////////////////////////////
// Concurrent assertions on the monitor top level, attached by bind
// Sampled at the rising edge, most are off while reset is asserted
// Failed assertions are also counted in fail_count
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module axil_monitor_checker
(
	input logic                      i_clk,
	input logic                      i_axi_reset_n,
	input axil_mon_pkg::counts_t     i_counts,
	input axil_mon_pkg::fault_vec_t  i_fault_flags,
	input logic                      i_fault,
	input axil_mon_pkg::fault_code_t i_first_fault
);

	import axil_mon_pkg::*;

	int fail_count = 0;

	// Flags only clear through reset
	flags_sticky: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		$past(i_axi_reset_n) |-> (($past(i_fault_flags) & ~i_fault_flags) == '0))
	else
	begin
		$error("fault flag cleared while reset was released");
		fail_count++;
	end

	// Summary bit tracks the flags
	fault_is_or: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		i_fault == (|i_fault_flags))
	else
	begin
		$error("o_fault differs from the OR of the flags");
		fail_count++;
	end

	counts_not_full: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		(i_counts.awr != '1) && (i_counts.wr != '1) && (i_counts.rd != '1))
	else
	begin
		$error("an outstanding count reached all ones");
		fail_count++;
	end

	// A code is held exactly when some fault was logged
	code_matches_fault: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		(i_first_fault == FC_NONE) == !i_fault)
	else
	begin
		$error("o_first_fault and o_fault disagree");
		fail_count++;
	end

endmodule

bind axil_bus_monitor axil_monitor_checker u_checker
(
	.i_clk         (i_clk),
	.i_axi_reset_n (i_axi_reset_n),
	.i_counts      (o_counts),
	.i_fault_flags (o_fault_flags),
	.i_fault       (o_fault),
	.i_first_fault (o_first_fault)
);

// File: verification/tb_axil_bus_monitor.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the AXI-lite bus monitor
// Bus values and expected results come from verification/axil_stim.txt
// An expect line spends one idle bus cycle and checks the state left
// by the drive lines before it
// Response value 9 in the stim file picks a random non-EXOKAY code
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_axil_bus_monitor;

	import axil_mon_pkg::*;

	logic i_clk;
	logic i_axi_reset_n;
	logic i_axi_awvalid;
	logic i_axi_awready;
	logic i_axi_wvalid;
	logic i_axi_wready;
	logic i_axi_bvalid;
	logic i_axi_bready;
	resp_t i_axi_bresp;
	logic i_axi_arvalid;
	logic i_axi_arready;
	logic i_axi_rvalid;
	logic i_axi_rready;
	resp_t i_axi_rresp;
	counts_t o_counts;
	fault_vec_t o_fault_flags;
	logic o_fault;
	fault_code_t o_first_fault;

	int cycle_count = 0;
	int cycle_limit = 1000;

	axil_bus_monitor dut0 (.*);

	initial
		i_clk = 1'b0;
	always #5 i_clk = ~i_clk;

	task automatic end_with_failure(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	// Watchdog on the whole run and on the bound assertions
	always @(posedge i_clk)
	begin
		cycle_count++;
		if (cycle_count >= cycle_limit)
			end_with_failure($sformatf("Run did not finish within %0d cycles", cycle_limit));
		else if (dut0.u_checker.fail_count != 0)
			end_with_failure("A bound assertion on the monitor outputs failed");
	end

	// Don't-care responses stay off EXOKAY
	function automatic resp_t stim_resp(input int val);
		int pick;
		if (val != 9)
			return resp_t'(val);
		pick = $urandom_range(2, 0);
		return (pick == 0) ? resp_t'(0) : resp_t'(pick + 1);
	endfunction

	task automatic drive_idle();
		{i_axi_awvalid, i_axi_awready, i_axi_wvalid, i_axi_wready} <= 4'b0;
		{i_axi_bvalid, i_axi_bready, i_axi_arvalid, i_axi_arready} <= 4'b0;
		{i_axi_rvalid, i_axi_rready} <= 2'b0;
		i_axi_bresp <= stim_resp(9);
		i_axi_rresp <= stim_resp(9);
	endtask

	// Columns 1 to 12 of a drive line, column 0 is the repeat count
	task automatic drive_cycle(input int v [0:12]);
		@(posedge i_clk);
		i_axi_awvalid <= (v[1] != 0);
		i_axi_awready <= (v[2] != 0);
		i_axi_wvalid <= (v[3] != 0);
		i_axi_wready <= (v[4] != 0);
		i_axi_bvalid <= (v[5] != 0);
		i_axi_bready <= (v[6] != 0);
		i_axi_bresp <= stim_resp(v[7]);
		i_axi_arvalid <= (v[8] != 0);
		i_axi_arready <= (v[9] != 0);
		i_axi_rvalid <= (v[10] != 0);
		i_axi_rready <= (v[11] != 0);
		i_axi_rresp <= stim_resp(v[12]);
	endtask

	task automatic apply_reset();
		@(posedge i_clk);
		i_axi_reset_n <= 1'b0;
		drive_idle();
		repeat (16) @(posedge i_clk);
		i_axi_reset_n <= 1'b1;
	endtask

	task automatic check_counts(input counts_t exp);
		if (o_counts !== exp)
			end_with_failure($sformatf(
				"ERROR at %0t: o_counts expected awr=%0d wr=%0d rd=%0d got awr=%0d wr=%0d rd=%0d",
				$time, exp.awr, exp.wr, exp.rd, o_counts.awr, o_counts.wr, o_counts.rd));
	endtask

	task automatic check_flags(input fault_vec_t exp);
		if (o_fault_flags !== exp)
			end_with_failure($sformatf("ERROR at %0t: o_fault_flags expected %03h got %03h",
				$time, exp, o_fault_flags));
	endtask

	task automatic check_fault(input logic exp);
		if (o_fault !== exp)
			end_with_failure($sformatf("ERROR at %0t: o_fault expected %0b got %0b",
				$time, exp, o_fault));
	endtask

	task automatic check_code(input fault_code_t exp);
		if (o_first_fault !== exp)
			end_with_failure($sformatf("ERROR at %0t: o_first_fault expected %0d got %0d",
				$time, exp, o_first_fault));
	endtask

	// Idle cycle lets the last drive line settle, outputs read at negedge
	task automatic expect_step(input counts_t cnt, input fault_vec_t flags,
		input fault_code_t code);
		@(posedge i_clk);
		drive_idle();
		@(negedge i_clk);
		check_counts(cnt);
		check_flags(flags);
		// Summary fault is up whenever any sticky flag is expected
		check_fault(flags != '0);
		check_code(code);
	endtask

	// First pass only sums cycles, second pass runs the lines
	task automatic walk_stim(input bit exec, output int cycles);
		int fd;
		int n;
		int v [0:12];
		int exp_code;
		logic [63:0] tag;
		logic [8*256-1:0] rest;
		logic [FAULT_N-1:0] exp_flags;
		cycles = 0;
		fd = $fopen("verification/axil_stim.txt", "r");
		if (fd == 0)
			end_with_failure("Stim file verification/axil_stim.txt could not be opened");
		while ($fscanf(fd, "%s", tag) == 1)
		begin
			if (tag == "#")
				n = $fgets(rest, fd);
			else if (tag == "D")
			begin
				n = $fscanf(fd, "%d %d %d %d %d %d %d %d %d %d %d %d %d", v[0], v[1], v[2],
					v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11], v[12]);
				if (n != 13)
					end_with_failure("Stim file has a drive line with missing values");
				cycles += v[0];
				if (exec)
					repeat (v[0]) drive_cycle(v);
			end
			else if (tag == "E")
			begin
				n = $fscanf(fd, "%d %d %d %h %d", v[0], v[1], v[2], exp_flags, exp_code);
				if (n != 5)
					end_with_failure("Stim file has an expect line with missing values");
				cycles += 1;
				if (exec)
					expect_step('{awr: count_t'(v[0]), wr: count_t'(v[1]), rd: count_t'(v[2])},
						fault_vec_t'(exp_flags), fault_code_t'(exp_code));
			end
			else if (tag == "R")
			begin
				cycles += 17;
				if (exec)
					apply_reset();
			end
			else
				end_with_failure("Stim file has a line of unknown kind");
		end
		$fclose(fd);
	endtask

	initial
	begin
		int seed_ret;
		int stim_cycles;
		seed_ret = $urandom(32'hbac6);
		i_axi_reset_n = 1'b0;
		{i_axi_awvalid, i_axi_awready, i_axi_wvalid, i_axi_wready} = 4'b0;
		{i_axi_bvalid, i_axi_bready, i_axi_arvalid, i_axi_arready} = 4'b0;
		{i_axi_rvalid, i_axi_rready, i_axi_bresp, i_axi_rresp} = 6'b0;
		walk_stim(1'b0, stim_cycles);
		cycle_limit = 2 * (stim_cycles + 16) + 64;
		repeat (16) @(posedge i_clk);
		i_axi_reset_n <= 1'b1;
		walk_stim(1'b1, stim_cycles);
		if (dut0.u_checker.fail_count == 0)
		begin
			$display("TEST RESULT: PASS");
			$finish;
		end
		else
		begin
			$display("Bound checker saw %0d failed assertions", dut0.u_checker.fail_count);
			$display("TEST RESULT: FAIL");
			$fatal(1);
		end
	end

endmodule

// File: verification/axil_stim.txt
# D cycles awv awr wv wr bv br bresp arv arr rv rr rresp (resp 9 = any code but EXOKAY)
# E awr_cnt wr_cnt rd_cnt flags_hex first_code, R = reset for 16 cycles
E 0 0 0 000 0
D 2 1 1 1 1 0 0 9 0 0 0 0 9
D 1 1 1 0 0 0 0 9 0 0 0 0 9
E 3 2 0 000 0
D 2 0 0 0 0 1 1 0 0 0 0 0 9
E 1 0 0 000 0
D 1 0 0 0 0 1 0 0 0 0 0 0 9
E 1 0 0 080 4
D 2 0 0 0 0 0 0 9 1 1 0 0 9
D 1 0 0 0 0 0 0 9 1 1 1 1 0
D 1 0 0 0 0 0 0 9 0 0 1 1 0
E 1 0 1 080 4
D 11 0 0 0 0 0 0 9 1 0 0 0 9
E 1 0 1 080 4
D 6 0 0 0 0 0 0 9 1 0 0 0 9
D 1 0 0 0 0 0 0 9 1 0 1 0 9
D 11 0 0 0 0 0 0 9 1 0 0 0 9
E 1 0 1 080 4
D 12 0 0 0 0 0 0 9 1 0 0 0 9
E 1 0 1 090 4
R
E 0 0 0 000 0
D 1 1 1 1 1 0 0 9 1 1 0 0 9
D 11 0 0 0 0 1 0 9 0 0 0 0 9
D 1 0 0 0 0 1 0 9 0 0 1 1 1
E 1 1 0 102 3
R
E 0 0 0 000 0

// File: sim.f
src/axil_mon_pkg.sv
src/axil_wr_monitor.sv
src/axil_rd_monitor.sv
src/axil_fault_log.sv
src/axil_bus_monitor.sv
verification/axil_monitor_checker.sv
verification/tb_axil_bus_monitor.sv
